// File: filelist.f
+incdir+include
logic/serial_link_pkg.sv
logic/link_cdc_fifo.sv
logic/serial_link_regs.sv
logic/serial_link_phy.sv
logic/serial_link_wrapper.sv
verification/serial_link_properties.sv
verification/tb_serial_link.sv

// File: Makefile
# Verilator flow for the serial link

VERILATOR ?= verilator
VFLAGS    ?= --timing --assert -Wno-fatal
TOP       ?= tb_serial_link
FILELIST  ?= filelist.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	@grep -q "TEST PASSED" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: verification/tb_serial_link.sv
// serial link testbench
// loops the link pins back and checks data, configuration and drop counting
`timescale 1ns/1ps
`default_nettype none

`include "serial_link_consts.svh"

module tb_serial_link;

  import serial_link_pkg::*;

  localparam int Depth = 2 ** `SL_FIFO_LOG_DEPTH;
  // about 90 words, 4 beats at divider 3 and two crossings each,
  // plus register polling, with a wide margin
  localparam int CycleLimit = 20000;

  logic                      clk_i, fast_clock, arst_n_i;
  logic                      in_valid_i, in_ready_o;
  sl_word_t                  in_data_i;
  logic                      out_valid_o, out_ready_i;
  sl_word_t                  out_data_o;
  logic                      cfg_valid_i, cfg_write_i, cfg_rsp_valid_o;
  logic [`SL_REG_ADDR_W-1:0] cfg_addr_i;
  logic [`SL_WORD_W-1:0]     cfg_wdata_i, cfg_rdata_o;
  logic [`SL_NUM_LANES-1:0]  ddr_o, ddr_i;
  logic                      ddr_rcv_clk_o, ddr_rcv_clk_i;

  integer   seed;
  int       err_cnt, test_cnt, test_fail_cnt, cycle_cnt, sent_cnt;
  sl_word_t sb_q[$];

  // loopback
  assign ddr_i         = ddr_o;
  assign ddr_rcv_clk_i = ddr_rcv_clk_o;

  serial_link_wrapper DUT (
    .clk_i(clk_i), .fast_clock(fast_clock), .arst_n_i(arst_n_i),
    .in_valid_i(in_valid_i), .in_data_i(in_data_i), .in_ready_o(in_ready_o),
    .out_valid_o(out_valid_o), .out_data_o(out_data_o), .out_ready_i(out_ready_i),
    .cfg_valid_i(cfg_valid_i), .cfg_write_i(cfg_write_i), .cfg_addr_i(cfg_addr_i),
    .cfg_wdata_i(cfg_wdata_i), .cfg_rsp_valid_o(cfg_rsp_valid_o),
    .cfg_rdata_o(cfg_rdata_o),
    .ddr_o(ddr_o), .ddr_rcv_clk_o(ddr_rcv_clk_o),
    .ddr_i(ddr_i), .ddr_rcv_clk_i(ddr_rcv_clk_i)
  );

  initial begin
    clk_i = 1'b0;
    forever #4 clk_i = ~clk_i;
  end

  initial begin
    fast_clock = 1'b0;
    forever #2 fast_clock = ~fast_clock;
  end

  // run limit
  always @(posedge clk_i) begin
    cycle_cnt++;
    if (cycle_cnt >= CycleLimit) begin
      $display("timeout: run went past %0d clk_i cycles", CycleLimit);
      $display("TEST FAILED");
      $finish;
    end
  end

  task automatic check_value(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    assert (got == exp) else begin
      $display("error: %s is 0x%08h, expected 0x%08h", name, got, exp);
      err_cnt++;
    end
  endtask

  // one request, waits for its response pulse
  task automatic cfg_access(input logic write, input logic [1:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    @(negedge clk_i);
    cfg_valid_i = 1'b1;
    cfg_write_i = write;
    cfg_addr_i  = addr;
    cfg_wdata_i = wdata;
    @(negedge clk_i);
    cfg_valid_i = 1'b0;
    while (!cfg_rsp_valid_o) begin
      @(negedge clk_i);
    end
    rdata = cfg_rdata_o;
    @(negedge clk_i);
  endtask

  task automatic cfg_check(input logic write, input logic [1:0] addr,
                           input logic [31:0] wdata, input logic [31:0] exp);
    logic [31:0] rdata;
    cfg_access(write, addr, wdata, rdata);
    check_value("cfg_rdata_o", rdata, exp);
  endtask

  // random words, each held until taken
  task automatic send_words(input int n);
    sl_word_t data;
    logic     ready_seen;
    @(negedge clk_i);
    for (int i = 0; i < n; i++) begin
      data       = $random(seed);
      in_valid_i = 1'b1;
      in_data_i  = data;
      ready_seen = 1'b0;
      while (!ready_seen) begin
        ready_seen = in_ready_o;
        @(negedge clk_i);
      end
      sb_q.push_back(data);
      sent_cnt++;
    end
    in_valid_i = 1'b0;
  endtask

  // subset mode skips words that were dropped on the way
  task automatic receive_words(input int n, input bit random_ready, input bit subset);
    int       got;
    logic     found;
    sl_word_t exp;
    logic [31:0] rnd;
    got = 0;
    while (got < n) begin
      @(negedge clk_i);
      rnd         = $random(seed);
      out_ready_i = random_ready ? rnd[0] : 1'b1;
      if (out_valid_o && out_ready_i) begin
        got++;
        found = 1'b0;
        if (subset) begin
          while (sb_q.size() > 0 && !found) begin
            exp   = sb_q.pop_front();
            found = exp == out_data_o;
          end
          assert (found) else begin
            $display("error: out_data_o 0x%08h is not among the words still due",
                     out_data_o);
            err_cnt++;
          end
        end else begin
          assert (sb_q.size() > 0) else begin
            $display("word on out_data_o with nothing left to expect");
            err_cnt++;
          end
          if (sb_q.size() > 0) begin
            check_value("out_data_o", out_data_o, sb_q.pop_front());
          end
        end
      end
    end
    @(negedge clk_i);
    out_ready_i = 1'b0;
  endtask

  task automatic end_test(input string name, input int err_before);
    test_cnt++;
    if (err_cnt == err_before) begin
      $display("test %0d %s: ok", test_cnt, name);
    end else begin
      test_fail_cnt++;
      $display("test %0d %s: failed with %0d errors", test_cnt, name, err_cnt - err_before);
    end
  endtask

  initial begin
    int          err_start, base;
    logic [31:0] rx0, drop0, rx1, drop1;
    int          polls;
    seed        = 32'h4f22_e6b8;
    err_cnt     = 0;
    test_cnt    = 0;
    cycle_cnt   = 0;
    sent_cnt    = 0;
    test_fail_cnt = 0;
    arst_n_i    = 1'b0;
    in_valid_i  = 1'b0;
    in_data_i   = '0;
    out_ready_i = 1'b0;
    cfg_valid_i = 1'b0;
    cfg_write_i = 1'b0;
    cfg_addr_i  = '0;
    cfg_wdata_i = '0;
    repeat (5) @(posedge clk_i);
    @(negedge clk_i);
    arst_n_i = 1'b1;

    // 1 reset state
    err_start = err_cnt;
    repeat (10) begin
      @(negedge clk_i);
      check_value("out_valid_o", out_valid_o, 0);
      check_value("cfg_rsp_valid_o", cfg_rsp_valid_o, 0);
      check_value("ddr_rcv_clk_o", ddr_rcv_clk_o, 0);
    end
    cfg_check(1'b0, `SL_REG_CTRL, 0, 2);
    end_test("reset state", err_start);

    // 2 divider clamping
    err_start = err_cnt;
    cfg_check(1'b1, `SL_REG_CLK_DIV, 5, 5);
    cfg_check(1'b1, `SL_REG_CLK_DIV, 0, 1);
    cfg_check(1'b1, `SL_REG_CLK_DIV, 40, 32);
    cfg_check(1'b0, `SL_REG_CLK_DIV, 0, 32);
    end_test("configuration", err_start);

    // 3 transfer at divider 1 and 3
    err_start = err_cnt;
    cfg_check(1'b1, `SL_REG_CTRL, 1, 1);
    cfg_check(1'b1, `SL_REG_CLK_DIV, 1, 1);
    // divider 1 outruns a half-rate reader, so the reader keeps up here
    fork
      send_words(32);
      receive_words(32, 1'b0, 1'b0);
    join
    cfg_check(1'b1, `SL_REG_CLK_DIV, 3, 3);
    fork
      send_words(32);
      receive_words(32, 1'b1, 1'b0);
    join
    check_value("scoreboard size", sb_q.size(), 0);
    end_test("link transfer", err_start);

    // 4 disabled link fills the tx FIFO, then drains in order
    err_start = err_cnt;
    cfg_check(1'b1, `SL_REG_CTRL, 0, 0);
    base = sent_cnt;
    fork
      send_words(Depth + 1);
      receive_words(Depth + 1, 1'b0, 1'b0);
      begin
        while (sent_cnt < base + Depth) begin
          @(negedge clk_i);
        end
        repeat (40) begin
          @(negedge clk_i);
          check_value("in_ready_o", in_ready_o, 0);
          check_value("out_valid_o", out_valid_o, 0);
        end
        // enabled but in link reset, pending words still held back
        cfg_check(1'b1, `SL_REG_CTRL, 3, 3);
        repeat (40) begin
          @(negedge clk_i);
          check_value("in_ready_o", in_ready_o, 0);
          check_value("out_valid_o", out_valid_o, 0);
        end
        cfg_check(1'b1, `SL_REG_CTRL, 1, 1);
      end
    join
    check_value("scoreboard size", sb_q.size(), 0);
    end_test("disabled link", err_start);

    // 5 stall the output, overflow the rx FIFO, count everything
    err_start = err_cnt;
    cfg_access(1'b0, `SL_REG_RX_COUNT, 0, rx0);
    cfg_access(1'b0, `SL_REG_DROP_COUNT, 0, drop0);
    send_words(3 * Depth);
    polls = 0;
    rx1   = rx0;
    drop1 = drop0;
    while ((rx1 - rx0) + (drop1 - drop0) != 3 * Depth && polls < 100) begin
      cfg_access(1'b0, `SL_REG_RX_COUNT, 0, rx1);
      cfg_access(1'b0, `SL_REG_DROP_COUNT, 0, drop1);
      polls++;
    end
    check_value("RX_COUNT + DROP_COUNT", (rx1 - rx0) + (drop1 - drop0), 3 * Depth);
    assert (rx1 - rx0 <= Depth) else begin
      $display("more words counted as received than the rx FIFO holds");
      err_cnt++;
    end
    receive_words(rx1 - rx0, 1'b0, 1'b1);
    repeat (20) begin
      @(negedge clk_i);
      check_value("out_valid_o", out_valid_o, 0);
    end
    sb_q.delete();
    end_test("back-pressure", err_start);

    $display("tests %0d, failed %0d, check errors %0d, property failures %0d",
             test_cnt, test_fail_cnt, err_cnt, DUT.u_props.fail_cnt);
    if (err_cnt == 0 && DUT.u_props.fail_cnt == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: verification/serial_link_properties.sv
// serial link properties, bound to the wrapper
// reset state, output ordering and register behaviour as concurrent assertions
`timescale 1ns/1ps
`default_nettype none

`include "serial_link_consts.svh"

module serial_link_properties (
  input logic                         clk_i,
  input logic                         fast_clock,
  input logic                         arst_n_i,
  input logic                         in_ready_o,
  input logic                         out_valid_o,
  input logic                         out_ready_i,
  input logic [`SL_WORD_W-1:0]        out_data_o,
  input logic                         cfg_rsp_valid_o,
  input logic [`SL_NUM_LANES-1:0]     ddr_o,
  input logic                         ddr_rcv_clk_o,
  input logic                         link_rst_i,
  input logic [`SL_CLK_DIV_W-1:0]     clk_div_i
);

  // failures seen so far, read by the testbench at the end
  int fail_cnt = 0;

  // everything quiet while reset is held
  reset_quiet: assert property (@(posedge clk_i)
    !arst_n_i |-> !in_ready_o && !out_valid_o && !cfg_rsp_valid_o &&
                  ddr_o == '0 && !ddr_rcv_clk_o)
    else begin
      $error("outputs active while reset is held");
      fail_cnt++;
    end

  // a stalled word stays put until it is taken
  out_hold: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_data_o))
    else begin
      $error("out_data_o changed or dropped while stalled");
      fail_cnt++;
    end

  // response is a single-cycle pulse, one request outstanding
  rsp_pulse: assert property (@(posedge clk_i) disable iff (!arst_n_i)
    cfg_rsp_valid_o |=> !cfg_rsp_valid_o)
    else begin
      $error("cfg_rsp_valid_o longer than one cycle");
      fail_cnt++;
    end

  // divider never leaves its legal range
  div_range: assert property (@(posedge fast_clock) disable iff (!arst_n_i)
    clk_div_i >= 1 && clk_div_i <= `SL_MAX_CLK_DIV)
    else begin
      $error("clock divider out of range");
      fail_cnt++;
    end

  // link reset freezes the strobe pin
  rst_freeze: assert property (@(posedge fast_clock) disable iff (!arst_n_i)
    link_rst_i |=> $stable(ddr_rcv_clk_o))
    else begin
      $error("strobe toggled during link reset");
      fail_cnt++;
    end

endmodule

bind serial_link_wrapper serial_link_properties u_props (
  .clk_i          (clk_i),
  .fast_clock     (fast_clock),
  .arst_n_i       (arst_n_i),
  .in_ready_o     (in_ready_o),
  .out_valid_o    (out_valid_o),
  .out_ready_i    (out_ready_i),
  .out_data_o     (out_data_o),
  .cfg_rsp_valid_o(cfg_rsp_valid_o),
  .ddr_o          (ddr_o),
  .ddr_rcv_clk_o  (ddr_rcv_clk_o),
  .link_rst_i     (link_rst),
  .clk_div_i      (clk_div)
);

`default_nettype wire

// File: logic/serial_link_wrapper.sv
// serial link top level
// data and configuration crossings into fast_clock, registers and phy
`timescale 1ns/1ps
`default_nettype none

`include "serial_link_consts.svh"

module serial_link_wrapper (
  input  logic                      clk_i,
  input  logic                      fast_clock,
  input  logic                      arst_n_i,
  // system data in
  input  logic                      in_valid_i,
  input  serial_link_pkg::sl_word_t in_data_i,
  output logic                      in_ready_o,
  // system data out
  output logic                      out_valid_o,
  output serial_link_pkg::sl_word_t out_data_o,
  input  logic                      out_ready_i,
  // configuration port
  input  logic                      cfg_valid_i,
  input  logic                      cfg_write_i,
  input  logic [`SL_REG_ADDR_W-1:0] cfg_addr_i,
  input  logic [`SL_WORD_W-1:0]     cfg_wdata_i,
  output logic                      cfg_rsp_valid_o,
  output logic [`SL_WORD_W-1:0]     cfg_rdata_o,
  // link pins
  output logic [`SL_NUM_LANES-1:0]  ddr_o,
  output logic                      ddr_rcv_clk_o,
  input  logic [`SL_NUM_LANES-1:0]  ddr_i,
  input  logic                      ddr_rcv_clk_i
);

  import serial_link_pkg::*;

  // fast-side data
  logic        tx_valid, tx_ready;
  sl_word_t    tx_data;
  logic        rx_valid, rx_ready, rx_push, rx_drop;
  sl_word_t    rx_data;
  // configuration on both sides
  sl_cfg_req_t cfg_req_sys, cfg_req_fast;
  logic        cfg_req_valid, cfg_req_ready;
  sl_cfg_rsp_t cfg_rsp_fast, cfg_rsp_sys;
  logic        cfg_rsp_valid, cfg_rsp_ready;
  // link control
  logic                     link_en, link_rst;
  logic [`SL_CLK_DIV_W-1:0] clk_div;

  assign cfg_req_sys = '{write: cfg_write_i, addr: cfg_addr_i, wdata: cfg_wdata_i};
  assign cfg_rdata_o = cfg_rsp_sys.rdata;
  // counted only when the rx FIFO really took the word
  assign rx_push     = rx_valid & rx_ready;

  // system to link data
  link_cdc_fifo #(.payload_t(sl_word_t)) i_tx_fifo (
    .wr_clk_i(clk_i), .wr_arst_n_i(arst_n_i),
    .wr_valid_i(in_valid_i), .wr_data_i(in_data_i), .wr_ready_o(in_ready_o),
    .rd_clk_i(fast_clock), .rd_arst_n_i(arst_n_i),
    .rd_valid_o(tx_valid), .rd_data_o(tx_data), .rd_ready_i(tx_ready)
  );

  // link to system data
  link_cdc_fifo #(.payload_t(sl_word_t)) i_rx_fifo (
    .wr_clk_i(fast_clock), .wr_arst_n_i(arst_n_i),
    .wr_valid_i(rx_valid), .wr_data_i(rx_data), .wr_ready_o(rx_ready),
    .rd_clk_i(clk_i), .rd_arst_n_i(arst_n_i),
    .rd_valid_o(out_valid_o), .rd_data_o(out_data_o), .rd_ready_i(out_ready_i)
  );

  // requests, one outstanding, so the FIFO always has room
  link_cdc_fifo #(.payload_t(sl_cfg_req_t)) i_cfg_req_fifo (
    .wr_clk_i(clk_i), .wr_arst_n_i(arst_n_i),
    .wr_valid_i(cfg_valid_i), .wr_data_i(cfg_req_sys), .wr_ready_o(),
    .rd_clk_i(fast_clock), .rd_arst_n_i(arst_n_i),
    .rd_valid_o(cfg_req_valid), .rd_data_o(cfg_req_fast), .rd_ready_i(cfg_req_ready)
  );

  // responses popped at once, giving a single-cycle pulse
  link_cdc_fifo #(.payload_t(sl_cfg_rsp_t)) i_cfg_rsp_fifo (
    .wr_clk_i(fast_clock), .wr_arst_n_i(arst_n_i),
    .wr_valid_i(cfg_rsp_valid), .wr_data_i(cfg_rsp_fast), .wr_ready_o(cfg_rsp_ready),
    .rd_clk_i(clk_i), .rd_arst_n_i(arst_n_i),
    .rd_valid_o(cfg_rsp_valid_o), .rd_data_o(cfg_rsp_sys), .rd_ready_i(1'b1)
  );

  serial_link_regs i_regs (
    .fast_clock (fast_clock),
    .arst_n_i   (arst_n_i),
    .req_valid_i(cfg_req_valid),
    .req_i      (cfg_req_fast),
    .req_ready_o(cfg_req_ready),
    .rsp_valid_o(cfg_rsp_valid),
    .rsp_o      (cfg_rsp_fast),
    .rsp_ready_i(cfg_rsp_ready),
    .rx_word_i  (rx_push),
    .drop_i     (rx_drop),
    .link_en_o  (link_en),
    .link_rst_o (link_rst),
    .clk_div_o  (clk_div)
  );

  serial_link_phy i_phy (
    .fast_clock   (fast_clock),
    .arst_n_i     (arst_n_i),
    .link_en_i    (link_en),
    .link_rst_i   (link_rst),
    .clk_div_i    (clk_div),
    .tx_valid_i   (tx_valid),
    .tx_data_i    (tx_data),
    .tx_ready_o   (tx_ready),
    .rx_valid_o   (rx_valid),
    .rx_data_o    (rx_data),
    .rx_ready_i   (rx_ready),
    .drop_o       (rx_drop),
    .ddr_o        (ddr_o),
    .ddr_rcv_clk_o(ddr_rcv_clk_o),
    .ddr_i        (ddr_i),
    .ddr_rcv_clk_i(ddr_rcv_clk_i)
  );

endmodule

`default_nettype wire

// File: logic/serial_link_phy.sv
// serial link physical layer
// tx splits words over the lanes beside a toggling strobe at the divided rate
// rx oversamples the strobe in fast_clock and rebuilds words per toggle
`timescale 1ns/1ps
`default_nettype none

`include "serial_link_consts.svh"

module serial_link_phy (
  input  logic                          fast_clock,
  input  logic                          arst_n_i,
  // link control from the registers
  input  logic                          link_en_i,
  input  logic                          link_rst_i,
  input  logic [`SL_CLK_DIV_W-1:0]      clk_div_i,
  // words to send
  input  logic                          tx_valid_i,
  input  serial_link_pkg::sl_word_t     tx_data_i,
  output logic                          tx_ready_o,
  // rebuilt words, no back-pressure towards the peer
  output logic                          rx_valid_o,
  output serial_link_pkg::sl_word_t     rx_data_o,
  input  logic                          rx_ready_i,
  output logic                          drop_o,
  // link pins
  output logic [`SL_NUM_LANES-1:0]      ddr_o,
  output logic                          ddr_rcv_clk_o,
  input  logic [`SL_NUM_LANES-1:0]      ddr_i,
  input  logic                          ddr_rcv_clk_i
);

  import serial_link_pkg::*;

  localparam int Lanes = `SL_NUM_LANES;
  localparam int Beats = `SL_BEATS;
  // counts up to Beats inclusive on the tx side
  localparam int BeatW = $clog2(Beats + 1);

  // transmitter state
  logic                     tx_busy_q;
  logic                     link_ok;
  logic                     tx_load;
  logic                     div_last;
  logic [`SL_CLK_DIV_W-1:0] div_cnt_q;
  logic [BeatW-1:0]         tx_beat_q;
  sl_word_t                 tx_shift_q;
  logic [Lanes-1:0]         ddr_q;
  logic                     strobe_q;

  // receiver state
  logic                     rcv_clk_q1, rcv_clk_q2, rcv_clk_q3;
  logic [Lanes-1:0]         ddr_in_q1, ddr_in_q2;
  logic                     beat_seen;
  logic [BeatW-1:0]         rx_beat_q;
  sl_word_t                 rx_shift_q;
  sl_word_t                 rx_word;
  logic                     rx_valid_q;
  sl_word_t                 rx_data_q;

  // the link only runs when enabled and out of link reset
  assign link_ok    = link_en_i & ~link_rst_i;
  assign tx_ready_o = link_ok & ~tx_busy_q;
  assign tx_load    = tx_valid_i & tx_ready_o;
  // clk_div_i is never zero, the registers clamp it
  assign div_last   = div_cnt_q == clk_div_i - 1'b1;

  // beat 0 goes out on load, the others after each divided period
  always_ff @(posedge fast_clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      tx_busy_q <= 1'b0;
      div_cnt_q <= '0;
      tx_beat_q <= '0;
      ddr_q     <= '0;
      strobe_q  <= 1'b0;
    end else if (link_rst_i) begin
      // pins hold, so the peer sees no extra strobe edge
      tx_busy_q <= 1'b0;
      div_cnt_q <= '0;
      tx_beat_q <= '0;
    end else if (tx_load) begin
      tx_busy_q <= 1'b1;
      div_cnt_q <= '0;
      tx_beat_q <= BeatW'(1);
      ddr_q     <= tx_data_i[Lanes-1:0];
      strobe_q  <= ~strobe_q;
    end else if (tx_busy_q && link_ok) begin
      if (!div_last) begin
        div_cnt_q <= div_cnt_q + 1'b1;
      end else begin
        div_cnt_q <= '0;
        if (tx_beat_q == BeatW'(Beats)) begin
          // last beat has been held for a full period
          tx_busy_q <= 1'b0;
        end else begin
          tx_beat_q <= tx_beat_q + 1'b1;
          ddr_q     <= tx_shift_q[Lanes-1:0];
          strobe_q  <= ~strobe_q;
        end
      end
    end
  end

  // remaining lanes of the word in flight
  always_ff @(posedge fast_clock) begin
    if (tx_load) begin
      tx_shift_q <= tx_data_i >> Lanes;
    end else if (tx_busy_q && link_ok && div_last && tx_beat_q != BeatW'(Beats)) begin
      tx_shift_q <= tx_shift_q >> Lanes;
    end
  end

  assign ddr_o         = ddr_q;
  assign ddr_rcv_clk_o = strobe_q;

  // strobe synchronizer plus edge flop, lanes delayed by the same two flops
  always_ff @(posedge fast_clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rcv_clk_q1 <= 1'b0;
      rcv_clk_q2 <= 1'b0;
      rcv_clk_q3 <= 1'b0;
      ddr_in_q1  <= '0;
      ddr_in_q2  <= '0;
    end else begin
      rcv_clk_q1 <= ddr_rcv_clk_i;
      rcv_clk_q2 <= rcv_clk_q1;
      rcv_clk_q3 <= rcv_clk_q2;
      ddr_in_q1  <= ddr_i;
      ddr_in_q2  <= ddr_in_q1;
    end
  end

  // either strobe edge marks one beat
  assign beat_seen = rcv_clk_q2 ^ rcv_clk_q3;
  // newest beat lands in the top lanes, the first beat ends up lowest
  assign rx_word   = {ddr_in_q2, rx_shift_q[`SL_WORD_W-1:Lanes]};

  always_ff @(posedge fast_clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      rx_beat_q  <= '0;
      rx_valid_q <= 1'b0;
    end else begin
      rx_valid_q <= 1'b0;
      if (link_rst_i) begin
        rx_beat_q <= '0;
      end else if (beat_seen) begin
        if (rx_beat_q == BeatW'(Beats - 1)) begin
          rx_beat_q  <= '0;
          rx_valid_q <= 1'b1;
        end else begin
          rx_beat_q <= rx_beat_q + 1'b1;
        end
      end
    end
  end

  // assembly and output word
  always_ff @(posedge fast_clock) begin
    if (beat_seen) begin
      rx_shift_q <= rx_word;
    end
    if (beat_seen && rx_beat_q == BeatW'(Beats - 1)) begin
      rx_data_q <= rx_word;
    end
  end

  // one-cycle push, lost if the rx FIFO cannot take it
  assign rx_valid_o = rx_valid_q;
  assign rx_data_o  = rx_data_q;
  assign drop_o     = rx_valid_q & ~rx_ready_i;

endmodule

`default_nettype wire

// File: logic/serial_link_regs.sv
// serial link configuration registers, fast_clock domain
// link enable, link reset and divider control plus rx and drop counters
`timescale 1ns/1ps
`default_nettype none

`include "serial_link_consts.svh"

module serial_link_regs (
  input  logic                         fast_clock,
  input  logic                         arst_n_i,
  // request from the configuration CDC FIFO
  input  logic                         req_valid_i,
  input  serial_link_pkg::sl_cfg_req_t req_i,
  output logic                         req_ready_o,
  // response towards the configuration CDC FIFO
  output logic                         rsp_valid_o,
  output serial_link_pkg::sl_cfg_rsp_t rsp_o,
  input  logic                         rsp_ready_i,
  // status pulses from the physical layer
  input  logic                         rx_word_i,
  input  logic                         drop_i,
  // link control
  output logic                         link_en_o,
  output logic                         link_rst_o,
  output logic [`SL_CLK_DIV_W-1:0]     clk_div_o
);

  import serial_link_pkg::*;

  logic                     busy_q;
  logic                     req_fire;
  logic                     link_en_q, link_en_d;
  logic                     link_rst_q, link_rst_d;
  logic [`SL_CLK_DIV_W-1:0] clk_div_q, clk_div_d;
  sl_word_t                 rx_count_q, drop_count_q;
  sl_cfg_rsp_t              rsp_q, rsp_d;

  // divider kept inside 1 to SL_MAX_CLK_DIV
  function automatic logic [`SL_CLK_DIV_W-1:0] clamp_div(input sl_word_t val);
    if (val == '0) begin
      return `SL_CLK_DIV_W'(1);
    end
    if (val > `SL_MAX_CLK_DIV) begin
      return `SL_CLK_DIV_W'(`SL_MAX_CLK_DIV);
    end
    return val[`SL_CLK_DIV_W-1:0];
  endfunction

  // one request in flight, blocked until its response is taken
  assign req_ready_o = ~busy_q;
  assign req_fire    = req_valid_i & req_ready_o;

  // register update and read-back value
  always_comb begin
    link_en_d  = link_en_q;
    link_rst_d = link_rst_q;
    clk_div_d  = clk_div_q;
    if (req_fire && req_i.write) begin
      case (req_i.addr)
        `SL_REG_CTRL: begin
          link_en_d  = req_i.wdata[0];
          link_rst_d = req_i.wdata[1];
        end
        `SL_REG_CLK_DIV: clk_div_d = clamp_div(req_i.wdata);
        // counters are read only
        default: ;
      endcase
    end
    case (req_i.addr)
      `SL_REG_CTRL:     rsp_d.rdata = `SL_WORD_W'({link_rst_d, link_en_d});
      `SL_REG_CLK_DIV:  rsp_d.rdata = `SL_WORD_W'(clk_div_d);
      `SL_REG_RX_COUNT: rsp_d.rdata = rx_count_q;
      default:          rsp_d.rdata = drop_count_q;
    endcase
  end

  always_ff @(posedge fast_clock or negedge arst_n_i) begin
    if (!arst_n_i) begin
      busy_q       <= 1'b0;
      link_en_q    <= 1'b0;
      link_rst_q   <= 1'b1;
      clk_div_q    <= `SL_CLK_DIV_W'(1);
      rx_count_q   <= '0;
      drop_count_q <= '0;
    end else begin
      link_en_q  <= link_en_d;
      link_rst_q <= link_rst_d;
      clk_div_q  <= clk_div_d;
      if (req_fire) begin
        busy_q <= 1'b1;
      end else if (rsp_ready_i) begin
        busy_q <= 1'b0;
      end
      // free-running status counters, wrap at the top
      if (rx_word_i) begin
        rx_count_q <= rx_count_q + 1'b1;
      end
      if (drop_i) begin
        drop_count_q <= drop_count_q + 1'b1;
      end
    end
  end

  // response payload, captured with the request
  always_ff @(posedge fast_clock) begin
    if (req_fire) begin
      rsp_q <= rsp_d;
    end
  end

  assign rsp_valid_o = busy_q;
  assign rsp_o       = rsp_q;
  assign link_en_o   = link_en_q;
  assign link_rst_o  = link_rst_q;
  assign clk_div_o   = clk_div_q;

endmodule

`default_nettype wire

// File: logic/link_cdc_fifo.sv
// dual-clock FIFO for the serial link crossings
// gray-coded pointers through two-flop synchronizers, payload set by type
`timescale 1ns/1ps
`default_nettype none

`include "serial_link_consts.svh"

module link_cdc_fifo #(
  parameter type payload_t = logic
) (
  // write side
  input  logic     wr_clk_i,
  input  logic     wr_arst_n_i,
  input  logic     wr_valid_i,
  input  payload_t wr_data_i,
  output logic     wr_ready_o,
  // read side
  input  logic     rd_clk_i,
  input  logic     rd_arst_n_i,
  output logic     rd_valid_o,
  output payload_t rd_data_o,
  input  logic     rd_ready_i
);

  localparam int LogDepth = `SL_FIFO_LOG_DEPTH;
  localparam int Depth    = 2 ** LogDepth;
  // one extra bit tells a full FIFO from an empty one
  localparam int PtrW     = LogDepth + 1;

  payload_t mem_q [Depth];

  logic [PtrW-1:0] wr_bin_q, wr_gray_q;
  logic [PtrW-1:0] rd_bin_q, rd_gray_q;
  // read pointer seen from the write side
  logic [PtrW-1:0] wr_rd_gray_q1, wr_rd_gray_q2;
  // write pointer seen from the read side
  logic [PtrW-1:0] rd_wr_gray_q1, rd_wr_gray_q2;
  logic [PtrW-1:0] wr_bin_d, rd_bin_d;
  logic            wr_alive_q;
  logic            full, empty;
  logic            push, pop;

  // full when the synced read pointer is one lap behind
  assign full  = wr_gray_q == {~wr_rd_gray_q2[PtrW-1 -: 2], wr_rd_gray_q2[PtrW-3:0]};
  assign empty = rd_gray_q == rd_wr_gray_q2;

  // ready stays low until the first write clock after reset release
  assign wr_ready_o = wr_alive_q & ~full;
  assign push       = wr_valid_i & wr_ready_o;

  assign rd_valid_o = ~empty;
  assign rd_data_o  = mem_q[rd_bin_q[LogDepth-1:0]];
  assign pop        = rd_valid_o & rd_ready_i;

  assign wr_bin_d = wr_bin_q + 1'b1;
  assign rd_bin_d = rd_bin_q + 1'b1;

  // storage, written in the write domain only
  always_ff @(posedge wr_clk_i) begin
    if (push) begin
      mem_q[wr_bin_q[LogDepth-1:0]] <= wr_data_i;
    end
  end

  // write pointer and read pointer synchronizer
  always_ff @(posedge wr_clk_i or negedge wr_arst_n_i) begin
    if (!wr_arst_n_i) begin
      wr_alive_q    <= 1'b0;
      wr_bin_q      <= '0;
      wr_gray_q     <= '0;
      wr_rd_gray_q1 <= '0;
      wr_rd_gray_q2 <= '0;
    end else begin
      wr_alive_q    <= 1'b1;
      wr_rd_gray_q1 <= rd_gray_q;
      wr_rd_gray_q2 <= wr_rd_gray_q1;
      if (push) begin
        wr_bin_q  <= wr_bin_d;
        wr_gray_q <= wr_bin_d ^ (wr_bin_d >> 1);
      end
    end
  end

  // read pointer and write pointer synchronizer
  always_ff @(posedge rd_clk_i or negedge rd_arst_n_i) begin
    if (!rd_arst_n_i) begin
      rd_bin_q      <= '0;
      rd_gray_q     <= '0;
      rd_wr_gray_q1 <= '0;
      rd_wr_gray_q2 <= '0;
    end else begin
      rd_wr_gray_q1 <= wr_gray_q;
      rd_wr_gray_q2 <= rd_wr_gray_q1;
      if (pop) begin
        rd_bin_q  <= rd_bin_d;
        rd_gray_q <= rd_bin_d ^ (rd_bin_d >> 1);
      end
    end
  end

endmodule

`default_nettype wire

// File: logic/serial_link_pkg.sv
// serial link types
// data word plus configuration request and response records
`default_nettype none

`include "serial_link_consts.svh"

package serial_link_pkg;

  // one payload word, lanes take it low bits first
  typedef logic [`SL_WORD_W-1:0] sl_word_t;

  // configuration request
  typedef struct packed {
    // high for a write, low for a read
    logic                      write;
    logic [`SL_REG_ADDR_W-1:0] addr;
    // ignored on reads
    logic [`SL_WORD_W-1:0]     wdata;
  } sl_cfg_req_t;

  // configuration response
  typedef struct packed {
    // register value, after the write for write requests
    logic [`SL_WORD_W-1:0] rdata;
  } sl_cfg_rsp_t;

endpackage

`default_nettype wire

// File: include/serial_link_consts.svh
// serial link constants
// lane and word geometry, CDC FIFO depth, register map and divider limits
`ifndef SERIAL_LINK_CONSTS_SVH
`define SERIAL_LINK_CONSTS_SVH

// data lanes driven per beat
`define SL_NUM_LANES 8
// payload word width
`define SL_WORD_W 32
// beats needed for one word
`define SL_BEATS (`SL_WORD_W / `SL_NUM_LANES)

// every CDC FIFO holds 2**SL_FIFO_LOG_DEPTH entries
`define SL_FIFO_LOG_DEPTH 2

// divider range and register width, 6 bits hold 32
`define SL_MAX_CLK_DIV 32
`define SL_CLK_DIV_W 6

// register map
`define SL_REG_ADDR_W 2
`define SL_REG_CTRL 2'd0
`define SL_REG_CLK_DIV 2'd1
`define SL_REG_RX_COUNT 2'd2
`define SL_REG_DROP_COUNT 2'd3

`endif
